/* all.f */
+incdir+testbench
hw/simd_alu_pkg.sv
hw/wb_operand_regs.sv
hw/simd_lane_adder.sv
hw/simd_lane_compare.sv
hw/simd_result_stage.sv
hw/simd_alu_top.sv
testbench/tb_simd_alu.sv

/* hw/simd_alu_pkg.sv */
/*
  Packed-SIMD ALU shared definitions
  Register map, operation codes, decoded command and lane views
*/
package simd_alu_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 2;

  // Word addresses of the register map
  localparam logic [ADDR_W-1:0] REG_OPA    = 2'd0;
  localparam logic [ADDR_W-1:0] REG_OPB    = 2'd1;
  localparam logic [ADDR_W-1:0] REG_CTRL   = 2'd2;
  localparam logic [ADDR_W-1:0] REG_RESULT = 2'd3;

  typedef enum logic {
    LANE8  = 1'b0,
    LANE16 = 1'b1
  } lane_width_e;

  // Code 0 is left invalid so a cleared control word does nothing
  typedef enum logic [4:0] {
    ADD    = 5'd1,  SUB    = 5'd2,  RADD   = 5'd3,  RSUB   = 5'd4,
    URADD  = 5'd5,  URSUB  = 5'd6,  KADD   = 5'd7,  KSUB   = 5'd8,
    UKADD  = 5'd9,  UKSUB  = 5'd10, CMPEQ  = 5'd11, SCMPLT = 5'd12,
    SCMPLE = 5'd13, UCMPLT = 5'd14, UCMPLE = 5'd15, SMIN   = 5'd16,
    SMAX   = 5'd17, UMIN   = 5'd18, UMAX   = 5'd19
  } simd_op_e;

  typedef struct packed {
    logic [22:0] rsvd_hi;
    lane_width_e width;
    logic [2:0]  rsvd_lo;
    simd_op_e    op;
  } ctrl_word_t;

  typedef enum logic [1:0] {WRAP, HALVE, SAT} add_mode_e;
  typedef enum logic [2:0] {EQ, LT, LE, MIN, MAX} cmp_kind_e;
  typedef enum logic [1:0] {RES_ADDER, RES_COMPARE, RES_NONE} res_class_e;

  typedef struct packed {
    lane_width_e width;
    logic        is_signed;
    logic        is_sub;
    add_mode_e   add_mode;
    cmp_kind_e   cmp_kind;
    res_class_e  res_class;
  } alu_cmd_t;

  // Same data word seen as bytes or as halfwords
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
  } lane_word_u;

  ////////////////////////////////////////////////////
  // Saturation limits
  ////////////////////////////////////////////////////
  localparam logic [7:0]  SAT_U_MAX8  = 8'hff;
  localparam logic [7:0]  SAT_S_MAX8  = 8'h7f;
  localparam logic [7:0]  SAT_S_MIN8  = 8'h80;
  localparam logic [15:0] SAT_U_MAX16 = 16'hffff;
  localparam logic [15:0] SAT_S_MAX16 = 16'h7fff;
  localparam logic [15:0] SAT_S_MIN16 = 16'h8000;

endpackage

/* hw/simd_alu_top.sv */
/*
  Packed-SIMD ALU top level
  Wishbone classic slave around a lane adder and lane comparator
*/
module simd_alu_top (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [simd_alu_pkg::ADDR_W-1:0]   wb_adr_i,
  input  logic [simd_alu_pkg::DATA_W-1:0]   wb_dat_i,
  // Only full-word accesses exist, byte selects are not decoded
  input  logic [3:0]                        wb_sel_i,
  output logic [simd_alu_pkg::DATA_W-1:0]   wb_dat_o,
  output logic                              wb_ack_o
);
  import simd_alu_pkg::*;

  lane_word_u          opa;
  lane_word_u          opb;
  alu_cmd_t            cmd;
  logic                launch;
  logic [DATA_W-1:0]   add_res;
  logic [DATA_W-1:0]   cmp_res;
  logic [DATA_W-1:0]   result;

  wb_operand_regs wb_operand_regs_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .result_i  (result),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .opa_o     (opa),
    .opb_o     (opb),
    .cmd_o     (cmd),
    .launch_o  (launch)
  );

  simd_lane_adder simd_lane_adder_i (
    .opa_i       (opa),
    .opb_i       (opb),
    .width_i     (cmd.width),
    .is_signed_i (cmd.is_signed),
    .is_sub_i    (cmd.is_sub),
    .add_mode_i  (cmd.add_mode),
    .add_res_o   (add_res)
  );

  simd_lane_compare simd_lane_compare_i (
    .opa_i       (opa),
    .opb_i       (opb),
    .width_i     (cmd.width),
    .is_signed_i (cmd.is_signed),
    .cmp_kind_i  (cmd.cmp_kind),
    .cmp_res_o   (cmp_res)
  );

  simd_result_stage simd_result_stage_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .launch_i    (launch),
    .res_class_i (cmd.res_class),
    .add_res_i   (add_res),
    .cmp_res_i   (cmp_res),
    .result_o    (result)
  );

endmodule

/* hw/simd_lane_adder.sv */
/*
  Lane adder and subtractor over bytes or halfwords
  Wrapping, halving and saturating result forms
*/
module simd_lane_adder (
  input  simd_alu_pkg::lane_word_u          opa_i,
  input  simd_alu_pkg::lane_word_u          opb_i,
  input  simd_alu_pkg::lane_width_e         width_i,
  input  logic                              is_signed_i,
  input  logic                              is_sub_i,
  input  simd_alu_pkg::add_mode_e           add_mode_i,
  output logic [simd_alu_pkg::DATA_W-1:0]   add_res_o
);
  import simd_alu_pkg::*;

  logic [3:0][7:0] b_in;
  logic [3:0]      cin;
  logic [3:0][8:0] sum;
  logic [3:0]      ext8;
  logic [1:0]      ext16;
  lane_word_u      wrap_res;
  lane_word_u      half8;
  lane_word_u      half16;
  lane_word_u      sat8;
  lane_word_u      sat16;

  ////////////////////////////////////////////////////
  // Byte adders with carry chain for halfwords
  ////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      b_in[i] = is_sub_i ? ~opb_i.b[i] : opb_i.b[i];
      // Upper byte of a halfword takes the carry from the lower one
      if ((i % 2 == 1) && (width_i == LANE16)) begin
        cin[i] = sum[i-1][8];
      end else begin
        cin[i] = is_sub_i;
      end
      sum[i] = {1'b0, opa_i.b[i]} + {1'b0, b_in[i]} + {8'd0, cin[i]};
    end
  end

  // Bit above the lane msb of the full-precision result
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      ext8[i] = (is_signed_i ? (opa_i.b[i][7] ^ b_in[i][7]) : is_sub_i) ^ sum[i][8];
    end
    for (int j = 0; j < 2; j++) begin
      ext16[j] = (is_signed_i ? (opa_i.h[j][15] ^ b_in[2*j+1][7]) : is_sub_i)
                 ^ sum[2*j+1][8];
    end
  end

  ////////////////////////////////////////////////////
  // Result forms
  ////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      wrap_res.b[i] = sum[i][7:0];
      half8.b[i]    = {ext8[i], sum[i][7:1]};
      if (is_signed_i) begin
        if (ext8[i] != sum[i][7]) begin
          sat8.b[i] = ext8[i] ? SAT_S_MIN8 : SAT_S_MAX8;
        end else begin
          sat8.b[i] = sum[i][7:0];
        end
      end else if (ext8[i]) begin
        // Carry on add, borrow on subtract
        sat8.b[i] = is_sub_i ? 8'h00 : SAT_U_MAX8;
      end else begin
        sat8.b[i] = sum[i][7:0];
      end
    end

    for (int j = 0; j < 2; j++) begin
      half16.h[j] = {ext16[j], sum[2*j+1][7:0], sum[2*j][7:1]};
      if (is_signed_i) begin
        if (ext16[j] != sum[2*j+1][7]) begin
          sat16.h[j] = ext16[j] ? SAT_S_MIN16 : SAT_S_MAX16;
        end else begin
          sat16.h[j] = wrap_res.h[j];
        end
      end else if (ext16[j]) begin
        sat16.h[j] = is_sub_i ? 16'h0000 : SAT_U_MAX16;
      end else begin
        sat16.h[j] = wrap_res.h[j];
      end
    end
  end

  always_comb begin
    case (add_mode_i)
      HALVE:   add_res_o = (width_i == LANE16) ? half16 : half8;
      SAT:     add_res_o = (width_i == LANE16) ? sat16 : sat8;
      default: add_res_o = wrap_res;
    endcase
  end

endmodule

/* hw/simd_lane_compare.sv */
/*
  Lane comparator for bytes or halfwords
  Produces compare masks and min/max lane picks
*/
module simd_lane_compare (
  input  simd_alu_pkg::lane_word_u          opa_i,
  input  simd_alu_pkg::lane_word_u          opb_i,
  input  simd_alu_pkg::lane_width_e         width_i,
  input  logic                              is_signed_i,
  input  simd_alu_pkg::cmp_kind_e           cmp_kind_i,
  output logic [simd_alu_pkg::DATA_W-1:0]   cmp_res_o
);
  import simd_alu_pkg::*;

  logic [3:0] eq_b;
  logic [3:0] ltu_b;
  logic [3:0] lts_b;
  logic [3:0] lt_top;
  logic [1:0] eq16;
  logic [1:0] lt16;
  logic [3:0] eq_m;
  logic [3:0] lt_m;
  logic [3:0] le_m;
  lane_word_u res;

  ////////////////////////////////////////////////////
  // Byte compares
  ////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      eq_b[i]   = opa_i.b[i] == opb_i.b[i];
      ltu_b[i]  = opa_i.b[i] < opb_i.b[i];
      lts_b[i]  = $signed(opa_i.b[i]) < $signed(opb_i.b[i]);
      lt_top[i] = is_signed_i ? lts_b[i] : ltu_b[i];
    end
  end

  // Halfword: sign only matters in the upper byte
  always_comb begin
    for (int j = 0; j < 2; j++) begin
      eq16[j] = eq_b[2*j+1] & eq_b[2*j];
      lt16[j] = lt_top[2*j+1] | (eq_b[2*j+1] & ltu_b[2*j]);
    end
  end

  // One mask bit per byte, shared by both bytes of a halfword
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      eq_m[i] = (width_i == LANE16) ? eq16[i/2] : eq_b[i];
      lt_m[i] = (width_i == LANE16) ? lt16[i/2] : lt_top[i];
      le_m[i] = eq_m[i] | lt_m[i];
    end
  end

  ////////////////////////////////////////////////////
  // Output select
  ////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      case (cmp_kind_i)
        EQ:      res.b[i] = {8{eq_m[i]}};
        LT:      res.b[i] = {8{lt_m[i]}};
        LE:      res.b[i] = {8{le_m[i]}};
        MIN:     res.b[i] = le_m[i] ? opa_i.b[i] : opb_i.b[i];
        default: res.b[i] = le_m[i] ? opb_i.b[i] : opa_i.b[i];
      endcase
    end
  end

  assign cmp_res_o = res;

endmodule

/* hw/simd_result_stage.sv */
/*
  Result register
  Loads the adder or comparator word when an operation launches
*/
module simd_result_stage (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              launch_i,
  input  simd_alu_pkg::res_class_e          res_class_i,
  input  logic [simd_alu_pkg::DATA_W-1:0]   add_res_i,
  input  logic [simd_alu_pkg::DATA_W-1:0]   cmp_res_i,
  output logic [simd_alu_pkg::DATA_W-1:0]   result_o
);
  import simd_alu_pkg::*;

  logic [DATA_W-1:0] result_d;
  logic [DATA_W-1:0] result_q;

  // Invalid ops give zero
  always_comb begin
    case (res_class_i)
      RES_ADDER:   result_d = add_res_i;
      RES_COMPARE: result_d = cmp_res_i;
      default:     result_d = '0;
    endcase
  end

  // Held until the next control write
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_q <= '0;
    end else if (launch_i) begin
      result_q <= result_d;
    end
  end

  assign result_o = result_q;

endmodule

/* hw/wb_operand_regs.sv */
/*
  Operand and control registers behind a Wishbone classic slave
  Decodes the control word into the ALU command
*/
module wb_operand_regs (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [simd_alu_pkg::ADDR_W-1:0]   wb_adr_i,
  input  logic [simd_alu_pkg::DATA_W-1:0]   wb_dat_i,
  input  logic [simd_alu_pkg::DATA_W-1:0]   result_i,
  output logic [simd_alu_pkg::DATA_W-1:0]   wb_dat_o,
  output logic                              wb_ack_o,
  output simd_alu_pkg::lane_word_u          opa_o,
  output simd_alu_pkg::lane_word_u          opb_o,
  output simd_alu_pkg::alu_cmd_t            cmd_o,
  output logic                              launch_o
);
  import simd_alu_pkg::*;

  logic        req;
  logic        ack_q;
  logic        launch_q;
  lane_word_u  opa_q;
  lane_word_u  opb_q;
  ctrl_word_t  ctrl_q;
  ctrl_word_t  wr_word;
  ctrl_word_t  ctrl_wr;

  // New request only while no ack is pending
  assign req = wb_cyc_i & wb_stb_i & ~ack_q;

  // Keep op and width, reserved bits stay zero
  assign wr_word = ctrl_word_t'(wb_dat_i);
  always_comb begin
    ctrl_wr       = '0;
    ctrl_wr.op    = wr_word.op;
    ctrl_wr.width = wr_word.width;
  end

  ////////////////////////////////////////////////////
  // Bus side registers
  ////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q    <= 1'b0;
      launch_q <= 1'b0;
      opa_q    <= '0;
      opb_q    <= '0;
      ctrl_q   <= '0;
    end else begin
      ack_q    <= req;
      launch_q <= req & wb_we_i & (wb_adr_i == REG_CTRL);
      if (req && wb_we_i) begin
        case (wb_adr_i)
          REG_OPA:  opa_q  <= wb_dat_i;
          REG_OPB:  opb_q  <= wb_dat_i;
          REG_CTRL: ctrl_q <= ctrl_wr;
          default: ;
        endcase
      end
    end
  end

  // Address is held by the master for the whole ack cycle
  always_comb begin
    case (wb_adr_i)
      REG_OPA:  wb_dat_o = opa_q;
      REG_OPB:  wb_dat_o = opb_q;
      REG_CTRL: wb_dat_o = ctrl_q;
      default:  wb_dat_o = result_i;
    endcase
  end

  ////////////////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////////////////
  always_comb begin
    cmd_o           = '0;
    cmd_o.width     = ctrl_q.width;
    cmd_o.add_mode  = WRAP;
    cmd_o.cmp_kind  = EQ;
    cmd_o.res_class = RES_ADDER;
    case (ctrl_q.op)
      ADD:    ;
      SUB:    cmd_o.is_sub = 1'b1;
      RADD:   {cmd_o.is_signed, cmd_o.add_mode} = {1'b1, HALVE};
      RSUB:   {cmd_o.is_signed, cmd_o.is_sub, cmd_o.add_mode} = {2'b11, HALVE};
      URADD:  cmd_o.add_mode = HALVE;
      URSUB:  {cmd_o.is_sub, cmd_o.add_mode} = {1'b1, HALVE};
      KADD:   {cmd_o.is_signed, cmd_o.add_mode} = {1'b1, SAT};
      KSUB:   {cmd_o.is_signed, cmd_o.is_sub, cmd_o.add_mode} = {2'b11, SAT};
      UKADD:  cmd_o.add_mode = SAT;
      UKSUB:  {cmd_o.is_sub, cmd_o.add_mode} = {1'b1, SAT};
      CMPEQ:  cmd_o.res_class = RES_COMPARE;
      SCMPLT: {cmd_o.is_signed, cmd_o.cmp_kind, cmd_o.res_class} = {1'b1, LT, RES_COMPARE};
      SCMPLE: {cmd_o.is_signed, cmd_o.cmp_kind, cmd_o.res_class} = {1'b1, LE, RES_COMPARE};
      UCMPLT: {cmd_o.cmp_kind, cmd_o.res_class} = {LT, RES_COMPARE};
      UCMPLE: {cmd_o.cmp_kind, cmd_o.res_class} = {LE, RES_COMPARE};
      SMIN:   {cmd_o.is_signed, cmd_o.cmp_kind, cmd_o.res_class} = {1'b1, MIN, RES_COMPARE};
      SMAX:   {cmd_o.is_signed, cmd_o.cmp_kind, cmd_o.res_class} = {1'b1, MAX, RES_COMPARE};
      UMIN:   {cmd_o.cmp_kind, cmd_o.res_class} = {MIN, RES_COMPARE};
      UMAX:   {cmd_o.cmp_kind, cmd_o.res_class} = {MAX, RES_COMPARE};
      default: cmd_o.res_class = RES_NONE;
    endcase
  end

  assign wb_ack_o = ack_q;
  assign launch_o = launch_q;
  assign opa_o    = opa_q;
  assign opb_o    = opb_q;

endmodule

/* testbench/tb_simd_alu_vectors.svh */
/*
  Vector table for the packed-SIMD ALU testbench
  Rows hold name, op, lane width, operand A, operand B and expected result
*/
`ifndef TB_SIMD_ALU_VECTORS_SVH
`define TB_SIMD_ALU_VECTORS_SVH

typedef struct packed {
  logic [8*12-1:0] name;
  simd_op_e        op;
  lane_width_e     width;
  logic [31:0]     opa;
  logic [31:0]     opb;
  logic [31:0]     expected;
} vec_t;

localparam int NUM_VECS = 42;

vec_t vectors [NUM_VECS] = '{
  // Wrapping carry is lost in bytes but chained in halfwords
  '{"add8_carry",   ADD,    LANE8,  32'h010203ff, 32'h01010101, 32'h02030400},
  '{"add16_carry",  ADD,    LANE16, 32'h010203ff, 32'h01010101, 32'h02030500},
  '{"sub8_borrow",  SUB,    LANE8,  32'h10000500, 32'h01010101, 32'h0fff04ff},
  '{"sub16_borrow", SUB,    LANE16, 32'h10000500, 32'h01010101, 32'h0eff03ff},
  // Halving
  '{"radd8",        RADD,   LANE8,  32'h7f80ff05, 32'h7f80ff03, 32'h7f80ff04},
  '{"rsub8",        RSUB,   LANE8,  32'h807f0010, 32'h7f800104, 32'h807fff06},
  '{"radd16",       RADD,   LANE16, 32'h80007fff, 32'h80007fff, 32'h80007fff},
  '{"uradd8",       URADD,  LANE8,  32'hffff0100, 32'hff010101, 32'hff800100},
  '{"uradd16",      URADD,  LANE16, 32'hffff0003, 32'hffff0001, 32'hffff0002},
  '{"ursub16",      URSUB,  LANE16, 32'h00000010, 32'h00020004, 32'hffff0006},
  '{"ursub8",       URSUB,  LANE8,  32'h00200310, 32'h01100104, 32'hff080106},
  '{"rsub16",       RSUB,   LANE16, 32'h00000005, 32'h00010001, 32'hffff0002},
  // Saturating clamps in both directions at each lane width
  '{"kadd8",        KADD,   LANE8,  32'h7f8010f0, 32'h01ff20f0, 32'h7f8030e0},
  '{"ksub8",        KSUB,   LANE8,  32'h807f0500, 32'h01ff0700, 32'h807ffe00},
  '{"kadd16",       KADD,   LANE16, 32'h80007fff, 32'hffff0001, 32'h80007fff},
  '{"ksub16",       KSUB,   LANE16, 32'h7fff8000, 32'hffff0001, 32'h7fff8000},
  '{"ukadd8",       UKADD,  LANE8,  32'hff800110, 32'h01800120, 32'hffff0230},
  '{"uksub8",       UKSUB,  LANE8,  32'h00100520, 32'h01200510, 32'h00000010},
  '{"ukadd16",      UKADD,  LANE16, 32'hffff1234, 32'h00011111, 32'hffff2345},
  '{"uksub16",      UKSUB,  LANE16, 32'h00015678, 32'h00021234, 32'h00004444},
  // Byte compares with lanes 0 and 3 differing in sign
  '{"cmpeq8",       CMPEQ,  LANE8,  32'h807f05ff, 32'h7f800501, 32'h0000ff00},
  '{"scmplt8",      SCMPLT, LANE8,  32'h807f05ff, 32'h7f800501, 32'hff0000ff},
  '{"scmple8",      SCMPLE, LANE8,  32'h807f05ff, 32'h7f800501, 32'hff00ffff},
  '{"ucmplt8",      UCMPLT, LANE8,  32'h807f05ff, 32'h7f800501, 32'h00ff0000},
  '{"ucmple8",      UCMPLE, LANE8,  32'h807f05ff, 32'h7f800501, 32'h00ffff00},
  '{"smin8",        SMIN,   LANE8,  32'h807f05ff, 32'h7f800501, 32'h808005ff},
  '{"smax8",        SMAX,   LANE8,  32'h807f05ff, 32'h7f800501, 32'h7f7f0501},
  '{"umin8",        UMIN,   LANE8,  32'h807f05ff, 32'h7f800501, 32'h7f7f0501},
  '{"umax8",        UMAX,   LANE8,  32'h807f05ff, 32'h7f800501, 32'h808005ff},
  '{"invalid_op0",  simd_op_e'(5'd0), LANE8, 32'h12345678, 32'h9abcdef0, 32'h00000000},
  // Halfword compares where the lane result disagrees with its low byte
  '{"cmpeq16",      CMPEQ,  LANE16, 32'h12345678, 32'h12345679, 32'hffff0000},
  '{"scmplt16",     SCMPLT, LANE16, 32'h800012ff, 32'h7fff1301, 32'hffffffff},
  '{"ucmplt16",     UCMPLT, LANE16, 32'h800012ff, 32'h7fff1301, 32'h0000ffff},
  '{"scmple16",     SCMPLE, LANE16, 32'h12340100, 32'h12340001, 32'hffff0000},
  // Equal upper bytes so the low byte decides as unsigned
  '{"scmplt16_lo",  SCMPLT, LANE16, 32'h12808000, 32'h12010001, 32'h0000ffff},
  '{"ucmple16",     UCMPLE, LANE16, 32'h12018000, 32'h12800001, 32'hffff0000},
  '{"smin16",       SMIN,   LANE16, 32'h800012ff, 32'h7fff1301, 32'h800012ff},
  '{"smax16",       SMAX,   LANE16, 32'h800012ff, 32'h7fff1301, 32'h7fff1301},
  '{"umin16",       UMIN,   LANE16, 32'hffff0001, 32'h00010002, 32'h00010001},
  '{"umax16",       UMAX,   LANE16, 32'h800012ff, 32'h7fff1301, 32'h80001301},
  '{"invalid_op31", simd_op_e'(5'd31), LANE16, 32'hffffffff, 32'h00000001, 32'h00000000},
  // Last row is nonzero for the hold check
  '{"add16_last",   ADD,    LANE16, 32'h00010002, 32'h00030004, 32'h00040006}
};

`endif

/* testbench/tb_simd_alu.sv */
/*
  Testbench for the packed-SIMD ALU
  Wishbone classic master tasks and a table driven vector loop
*/
module tb_simd_alu;
  timeunit 1ns;
  timeprecision 100ps;
  import simd_alu_pkg::*;

  localparam int ACK_TIMEOUT = 20;

  logic              clk_i;
  logic              rst_n_i;
  logic              wb_cyc_i;
  logic              wb_stb_i;
  logic              wb_we_i;
  logic [ADDR_W-1:0] wb_adr_i;
  logic [31:0]       wb_dat_i;
  logic [3:0]        wb_sel_i;
  logic [31:0]       wb_dat_o;
  logic              wb_ack_o;

  `include "tb_simd_alu_vectors.svh"

  simd_alu_top simd_alu_top_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      $display("tests failed");
      $fatal(1, "Stopping at the first wrong value");
    end
  endtask

  // Samples 1 ns after each edge and returns with ack high
  task automatic wait_ack();
    int cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < ACK_TIMEOUT) begin
      @(posedge clk_i);
      #1;
      seen = wb_ack_o;
      cycles++;
    end
    if (!seen) begin
      $display("tests failed");
      $fatal(1, "No acknowledge arrived within %0d cycles", ACK_TIMEOUT);
    end
  endtask

  task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [31:0] dat);
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wait_ack();
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [31:0] dat);
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = adr;
    wait_ack();
    dat = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    logic [31:0] ctrl;
    clk_i    = 1'b0;
    rst_n_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = 4'hf;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // No stray acknowledge out of reset
    check("reset_ack", 32'h0, {31'd0, wb_ack_o});

    // All registers clear after reset
    for (int r = 0; r < 4; r++) begin
      wb_read(r[ADDR_W-1:0], rd);
      check($sformatf("reset_reg%0d", r), 32'h0, rd);
    end

    wb_write(REG_OPA, 32'ha5c30f81);
    wb_write(REG_OPB, 32'h1e2d3c4b);
    wb_read(REG_OPA, rd);
    check("readback_opa", 32'ha5c30f81, rd);
    wb_read(REG_OPB, rd);
    check("readback_opb", 32'h1e2d3c4b, rd);
    // Only op in bits 4..0 and width in bit 8 survive
    wb_write(REG_CTRL, 32'hffffffff);
    wb_read(REG_CTRL, rd);
    check("readback_ctrl", 32'h0000011f, rd);

    for (int i = 0; i < NUM_VECS; i++) begin
      ctrl = {23'd0, vectors[i].width, 3'd0, vectors[i].op};
      wb_write(REG_OPA, vectors[i].opa);
      wb_write(REG_OPB, vectors[i].opb);
      wb_write(REG_CTRL, ctrl);
      wb_read(REG_RESULT, rd);
      check(string'(vectors[i].name), vectors[i].expected, rd);
    end

    // New operands alone must not disturb the result
    wb_write(REG_OPA, 32'hdeadbeef);
    wb_write(REG_OPB, 32'h0badf00d);
    wb_write(REG_RESULT, 32'h55555555);
    wb_read(REG_RESULT, rd);
    check("result_hold", vectors[NUM_VECS-1].expected, rd);

    $display("all tests passed");
    $finish;
  end

endmodule
